//--- Bender.yml
package:
  name: pipeline_cpu

sources:
  - include_dirs:
      - common
    files:
      - common/isaPkg.sv
      - common/pipePkg.sv
      - common/stageIf.sv
      - decode/registerFile.sv
      - decode/decodeStage.sv
      - src/fetchStage.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/pipelineCpu.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/pipelineCpuTb.sv

//--- bench/pipelineCpuTb.sv
`default_nettype none
`include "cpu_consts.svh"

module pipelineCpuTb;
	import isaPkg::*;
	import pipePkg::*;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 5;
	localparam int driveDelay = 5;
	localparam int progLen = 200;
	localparam int timeoutCycles = progLen * 2 + 20;
	localparam int drainCycles = 6;

	logic clk;
	logic reset;
	wordT instr;
	wordT pc;
	logic wbValid;
	regIdxT wbReg;
	wordT wbData;

	logic [31:0] lfsrState;
	wordT prog [progLen];
	regIdxT expReg [$];
	wordT expData [$];
	wordT expPc;
	logic pcHeld;
	int errors;
	int retIdx;

	pipelineCpu u_dut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc(pc),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	////////////////////////////////////////
	// random source
	////////////////////////////////////////
	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	////////////////////////////////////////
	// program generation
	////////////////////////////////////////
	function automatic wordT encodeR(input regIdxT rs, input regIdxT rt, input regIdxT rd,
			input logic [5:0] funct);
		return {opR, rs, rt, rd, 5'b00000, funct};
	endfunction

	function automatic wordT encodeI(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// selections 5..7 give an unsupported funct (nor)
	function automatic logic [5:0] functFromSel(input logic [2:0] sel);
		case (sel)
			3'd0: return fnAdd;
			3'd1: return fnSub;
			3'd2: return fnAnd;
			3'd3: return fnOr;
			3'd4: return fnSlt;
			default: return 6'b100111;
		endcase
	endfunction

	// beq, j, ori and slti are outside the kept set
	function automatic logic [5:0] unknownOpcode(input logic [1:0] sel);
		case (sel)
			2'd0: return 6'b000100;
			2'd1: return 6'b000010;
			2'd2: return 6'b001101;
			default: return 6'b001010;
		endcase
	endfunction

	task automatic buildProgram();
		logic [2:0] kind;
		logic [31:0] hi;
		logic [31:0] lo;
		logic [15:0] memImm;
		regIdxT rs;
		regIdxT rt;
		regIdxT rd;
		regIdxT base;
		for (int i = 0; i < progLen; i++) begin
			kind = 3'(randBits(3));
			rs = regIdxT'(randBits(3));
			rt = regIdxT'(randBits(3));
			rd = regIdxT'(randBits(3));
			// half the memory ops use $0 as base so that offsets alias above bit 6
			base = randBits(1) ? regIdxT'(0) : rs;
			hi = randBits(9);
			lo = randBits(3);
			memImm = {hi[8:0], 2'b00, lo[2:0], 2'b00};
			case (kind)
				3'd0, 3'd1, 3'd2: prog[i] = encodeR(rs, rt, rd, functFromSel(3'(randBits(3))));
				3'd3, 3'd4: prog[i] = encodeI(opAddi, rs, rt, 16'(randBits(16)));
				3'd5: prog[i] = encodeI(opLw, base, rt, memImm);
				3'd6: prog[i] = encodeI(opSw, base, rt, memImm);
				default: prog[i] = encodeI(unknownOpcode(2'(randBits(2))), rs, rt,
					16'(randBits(16)));
			endcase
		end
	endtask

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic logic functKnown(input logic [5:0] funct);
		case (funct)
			fnAdd, fnSub, fnAnd, fnOr, fnSlt: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic wordT aluModel(input logic [5:0] funct, input wordT a, input wordT b);
		wordT diff;
		diff = a - b;
		case (funct)
			fnAdd: return a + b;
			fnSub: return diff;
			fnAnd: return a & b;
			fnOr: return a | b;
			// slt is the sign bit of the difference
			default: return {31'b0, diff[31]};
		endcase
	endfunction

	// sequential execution that records every nonzero register write
	task automatic runModel();
		wordT regs [`CPU_REG_COUNT];
		wordT dmem [`CPU_DMEM_WORDS];
		wordT w;
		wordT imm;
		wordT addr;
		wordT result;
		regIdxT dest;
		logic write;
		for (int i = 0; i < `CPU_REG_COUNT; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
			dmem[i] = '0;
		end
		for (int i = 0; i < progLen; i++) begin
			w = prog[i];
			imm = {{16{w[15]}}, w[15:0]};
			addr = regs[w[25:21]] + imm;
			dest = w[20:16];
			write = 1'b0;
			result = '0;
			case (w[31:26])
				opR: begin
					dest = w[15:11];
					write = functKnown(w[5:0]);
					result = aluModel(w[5:0], regs[w[25:21]], regs[w[20:16]]);
				end
				opAddi: begin
					write = 1'b1;
					result = addr;
				end
				opLw: begin
					write = 1'b1;
					result = dmem[addr[`CPU_DMEM_INDEX_BITS+1:2]];
				end
				opSw: dmem[addr[`CPU_DMEM_INDEX_BITS+1:2]] = regs[w[20:16]];
				default: write = 1'b0;
			endcase
			if (write && (dest != '0)) begin
				regs[dest] = result;
				expReg.push_back(dest);
				expData.push_back(result);
			end
		end
	endtask

	function automatic wordT wordAt(input int k);
		if ((k >= 0) && (k < progLen)) begin
			return prog[k];
		end
		return '0;
	endfunction

	// word k in decode behind a load in execute that writes one of its fields
	function automatic logic predictStall(input int k);
		wordT prev;
		wordT cur;
		if (k <= 0) begin
			return 1'b0;
		end
		prev = wordAt(k - 1);
		cur = wordAt(k);
		return (prev[31:26] == opLw) &&
			((prev[20:16] == cur[25:21]) || (prev[20:16] == cur[20:16]));
	endfunction

	////////////////////////////////////////
	// checks
	////////////////////////////////////////
	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL %s: got %h, expected %h at time %0t", name, actual, expected, $time);
			errors++;
		end
	endtask

	// sample at the falling edge and drive the next word after the rising edge
	task automatic checkCycle(input int cycle);
		@(negedge clk);
		checkValue("pc", pc, expPc);
		if (cycle < 4) begin
			checkValue("wbValid", 32'(wbValid), 32'd0);
		end
		if (wbValid) begin
			if (retIdx < expReg.size()) begin
				checkValue("wbReg", 32'(wbReg), 32'(expReg[retIdx]));
				checkValue("wbData", wbData, expData[retIdx]);
				retIdx++;
			end else begin
				$display("unexpected retirement of register %0d after all expected writes",
					wbReg);
				errors++;
			end
		end
		// a load-use pair holds the pc for exactly one cycle
		if (!pcHeld && predictStall(int'(expPc >> 2) - 1)) begin
			pcHeld = 1'b1;
		end else begin
			pcHeld = 1'b0;
			expPc = expPc + `CPU_PC_STEP;
		end
		@(posedge clk);
		#(driveDelay);
		instr = wordAt(int'(pc >> 2));
	endtask

	initial begin
		int cycle;
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		errors = 0;
		retIdx = 0;
		expPc = '0;
		pcHeld = 1'b0;
		lfsrState = 32'd18;
		buildProgram();
		runModel();
		$display("program of %0d words, %0d expected retirements", progLen, expReg.size());

		repeat (resetCycles) @(posedge clk);
		#(driveDelay);
		reset = 1'b0;
		instr = wordAt(int'(pc >> 2));

		// run the whole program through the pipeline, then a few cycles more
		cycle = 0;
		while ((int'(expPc >> 2) < progLen + drainCycles) && (cycle < progLen * 2)) begin
			checkCycle(cycle);
			cycle++;
		end

		if (retIdx < expReg.size()) begin
			$display("missing retirements: %0d of %0d expected register writes never appeared",
				expReg.size() - retIdx, expReg.size());
			errors++;
		end
		$display("done after %0d cycles: %0d errors, %0d of %0d retirements seen",
			cycle, errors, retIdx, expReg.size());
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	////////////////////////////////////////
	// watchdog
	////////////////////////////////////////
	initial begin
		#(clkPeriod * (resetCycles + timeoutCycles));
		$display("timeout: run did not finish within %0d cycles after reset", timeoutCycles);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- common/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// data and address width
`define CPU_XLEN 32

// register file geometry
`define CPU_REG_COUNT 32
`define CPU_REG_BITS 5

// data memory, word index comes from address bits 6..2
`define CPU_DMEM_WORDS 32
`define CPU_DMEM_INDEX_BITS 5

// byte step between instructions
`define CPU_PC_STEP 4

`endif

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

	// primary opcode field, bits 31..26
	typedef enum logic [5:0] {
		opR    = 6'b000000,
		opAddi = 6'b001000,
		opLw   = 6'b100011,
		opSw   = 6'b101011
	} opcodeT;

	// funct field of R-type, bits 5..0
	typedef enum logic [5:0] {
		fnAdd = 6'b100000,
		fnSub = 6'b100010,
		fnAnd = 6'b100100,
		fnOr  = 6'b100101,
		fnSlt = 6'b101010
	} functT;

	// ALU operations
	typedef enum logic [2:0] {
		aluAnd = 3'b000,
		aluOr  = 3'b001,
		aluAdd = 3'b010,
		aluSub = 3'b110,
		aluSlt = 3'b111
	} aluOpT;

endpackage

`default_nettype wire

//--- common/pipePkg.sv
`default_nettype none
`include "cpu_consts.svh"

package pipePkg;

	typedef logic [`CPU_XLEN-1:0] wordT;
	typedef logic [`CPU_REG_BITS-1:0] regIdxT;

	// execute stage controls
	typedef struct packed {
		logic aluSrc;
		isaPkg::aluOpT aluOp;
		logic useFunct;
	} exCtrlT;

	// memory stage controls
	typedef struct packed {
		logic memRead;
		logic memWrite;
	} memCtrlT;

	// writeback controls, regWrite is never set for register 0
	typedef struct packed {
		logic regWrite;
		logic memToReg;
	} wbCtrlT;

endpackage

`default_nettype wire

//--- common/stageIf.sv
`default_nettype none

// decode/execute pipeline register contents
interface idExIf;
	import isaPkg::*;
	import pipePkg::*;

	exCtrlT exCtrl;
	memCtrlT memCtrl;
	wbCtrlT wbCtrl;
	wordT rsVal;
	wordT rtVal;
	wordT imm;
	regIdxT rs;
	regIdxT rt;
	regIdxT rd;
	functT funct;

	modport decode (output exCtrl, memCtrl, wbCtrl, rsVal, rtVal, imm, rs, rt, rd, funct);
	modport execute (input exCtrl, memCtrl, wbCtrl, rsVal, rtVal, imm, rs, rt, rd, funct);
endinterface

// execute/memory pipeline register contents
interface exMemIf;
	import pipePkg::*;

	memCtrlT memCtrl;
	wbCtrlT wbCtrl;
	wordT aluResult;
	wordT storeData;
	regIdxT rd;

	modport execute (output memCtrl, wbCtrl, aluResult, storeData, rd);
	modport memory (input memCtrl, wbCtrl, aluResult, storeData, rd);
endinterface

`default_nettype wire

//--- decode/decodeStage.sv
`default_nettype none
`include "cpu_consts.svh"

module decodeStage (
	input  logic            clk,
	input  logic            reset,
	input  pipePkg::wordT   idInstr,
	input  logic            wbWrite,
	input  pipePkg::regIdxT wbReg,
	input  pipePkg::wordT   wbData,
	output logic            stall,
	idExIf.decode           idEx
);
	import isaPkg::*;
	import pipePkg::*;

	opcodeT opcode;
	regIdxT rsField;
	regIdxT rtField;
	regIdxT rdField;
	regIdxT destReg;
	wordT rsVal;
	wordT rtVal;
	wordT imm;
	exCtrlT exCtrl;
	memCtrlT memCtrl;
	wbCtrlT wbCtrl;

	assign opcode  = opcodeT'(idInstr[31:26]);
	assign rsField = idInstr[25:21];
	assign rtField = idInstr[20:16];
	assign rdField = idInstr[15:11];
	assign imm     = {{(`CPU_XLEN-16){idInstr[15]}}, idInstr[15:0]};

	registerFile u_regFile (
		.clk(clk),
		.reset(reset),
		.rs(rsField),
		.rt(rtField),
		.wbWrite(wbWrite),
		.wbReg(wbReg),
		.wbData(wbData),
		.rsVal(rsVal),
		.rtVal(rtVal)
	);

	////////////////////////////////////////
	// main control
	////////////////////////////////////////
	always_comb begin
		exCtrl = '0;
		exCtrl.aluOp = aluAdd;
		memCtrl = '0;
		wbCtrl = '0;
		destReg = rtField;
		case (opcode)
			opR: begin
				exCtrl.useFunct = 1'b1;
				wbCtrl.regWrite = 1'b1;
				destReg = rdField;
			end
			opAddi: begin
				exCtrl.aluSrc = 1'b1;
				wbCtrl.regWrite = 1'b1;
			end
			opLw: begin
				exCtrl.aluSrc = 1'b1;
				memCtrl.memRead = 1'b1;
				wbCtrl.regWrite = 1'b1;
				wbCtrl.memToReg = 1'b1;
			end
			opSw: begin
				exCtrl.aluSrc = 1'b1;
				memCtrl.memWrite = 1'b1;
			end
			// unknown opcode stays a bubble
			default: begin
			end
		endcase
		// $0 is never written
		if (destReg == '0) begin
			wbCtrl.regWrite = 1'b0;
		end
	end

	// load in execute feeding this instruction
	assign stall = idEx.memCtrl.memRead && ((idEx.rt == rsField) || (idEx.rt == rtField));

	////////////////////////////////////////
	// decode/execute register
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idEx.exCtrl <= '0;
			idEx.memCtrl <= '0;
			idEx.wbCtrl <= '0;
			idEx.rsVal <= '0;
			idEx.rtVal <= '0;
			idEx.imm <= '0;
			idEx.rs <= '0;
			idEx.rt <= '0;
			idEx.rd <= '0;
			idEx.funct <= functT'('0);
		end else begin
			// a stall sends a bubble
			idEx.exCtrl <= stall ? exCtrlT'('0) : exCtrl;
			idEx.memCtrl <= stall ? memCtrlT'('0) : memCtrl;
			idEx.wbCtrl <= stall ? wbCtrlT'('0) : wbCtrl;
			idEx.rsVal <= rsVal;
			idEx.rtVal <= rtVal;
			idEx.imm <= imm;
			idEx.rs <= rsField;
			idEx.rt <= rtField;
			idEx.rd <= destReg;
			idEx.funct <= functT'(idInstr[5:0]);
		end
	end

endmodule

`default_nettype wire

//--- decode/registerFile.sv
`default_nettype none
`include "cpu_consts.svh"

module registerFile (
	input  logic            clk,
	input  logic            reset,
	input  pipePkg::regIdxT rs,
	input  pipePkg::regIdxT rt,
	input  logic            wbWrite,
	input  pipePkg::regIdxT wbReg,
	input  pipePkg::wordT   wbData,
	output pipePkg::wordT   rsVal,
	output pipePkg::wordT   rtVal
);
	import pipePkg::*;

	wordT regs [`CPU_REG_COUNT];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite) begin
			regs[wbReg] <= wbData;
		end
	end

	// same-cycle writeback is visible to the reader
	assign rsVal = (wbWrite && (wbReg == rs)) ? wbData : regs[rs];
	assign rtVal = (wbWrite && (wbReg == rt)) ? wbData : regs[rt];

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/isaPkg.sv
common/pipePkg.sv
common/stageIf.sv
decode/registerFile.sv
decode/decodeStage.sv
src/fetchStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineCpu.sv
bench/pipelineCpuTb.sv

//--- src/executeStage.sv
`default_nettype none
`include "cpu_consts.svh"

module executeStage (
	input  logic            clk,
	input  logic            reset,
	idExIf.execute          idEx,
	input  pipePkg::wordT   wbData,
	input  logic            wbWrite,
	input  pipePkg::regIdxT wbReg,
	exMemIf.execute         exMem
);
	import isaPkg::*;
	import pipePkg::*;

	aluOpT aluOp;
	logic functOk;
	wordT opA;
	wordT fwdB;
	wordT opB;
	wordT diff;
	wordT aluResult;

	////////////////////////////////////////
	// ALU operation select
	////////////////////////////////////////
	always_comb begin
		aluOp = idEx.exCtrl.aluOp;
		functOk = 1'b1;
		if (idEx.exCtrl.useFunct) begin
			case (idEx.funct)
				fnAdd: aluOp = aluAdd;
				fnSub: aluOp = aluSub;
				fnAnd: aluOp = aluAnd;
				fnOr:  aluOp = aluOr;
				fnSlt: aluOp = aluSlt;
				default: functOk = 1'b0;
			endcase
		end
	end

	////////////////////////////////////////
	// forwarding
	////////////////////////////////////////
	// newest producer wins: memory stage, then writeback
	always_comb begin
		if (exMem.wbCtrl.regWrite && (exMem.rd == idEx.rs)) begin
			opA = exMem.aluResult;
		end else if (wbWrite && (wbReg == idEx.rs)) begin
			opA = wbData;
		end else begin
			opA = idEx.rsVal;
		end

		if (exMem.wbCtrl.regWrite && (exMem.rd == idEx.rt)) begin
			fwdB = exMem.aluResult;
		end else if (wbWrite && (wbReg == idEx.rt)) begin
			fwdB = wbData;
		end else begin
			fwdB = idEx.rtVal;
		end
	end

	assign opB  = idEx.exCtrl.aluSrc ? idEx.imm : fwdB;
	assign diff = opA - opB;

	always_comb begin
		case (aluOp)
			aluAnd: aluResult = opA & opB;
			aluOr:  aluResult = opA | opB;
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = diff;
			// sign of the raw difference
			aluSlt: aluResult = {{(`CPU_XLEN-1){1'b0}}, diff[`CPU_XLEN-1]};
			default: aluResult = '0;
		endcase
	end

	////////////////////////////////////////
	// execute/memory register
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			exMem.memCtrl <= '0;
			exMem.wbCtrl <= '0;
			exMem.aluResult <= '0;
			exMem.storeData <= '0;
			exMem.rd <= '0;
		end else begin
			exMem.memCtrl <= idEx.memCtrl;
			exMem.wbCtrl.regWrite <= idEx.wbCtrl.regWrite && functOk;
			exMem.wbCtrl.memToReg <= idEx.wbCtrl.memToReg;
			exMem.aluResult <= aluResult;
			exMem.storeData <= fwdB;
			exMem.rd <= idEx.rd;
		end
	end

endmodule

`default_nettype wire

//--- src/fetchStage.sv
`default_nettype none
`include "cpu_consts.svh"

module fetchStage (
	input  logic          clk,
	input  logic          reset,
	input  logic          stall,
	input  pipePkg::wordT instr,
	output pipePkg::wordT pc,
	output pipePkg::wordT idInstr
);

	////////////////////////////////////////
	// program counter
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (!stall) begin
			pc <= pc + `CPU_PC_STEP;
		end
	end

	////////////////////////////////////////
	// fetch/decode register
	////////////////////////////////////////
	// word zero decodes as a no-op, so reset leaves a harmless bubble
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			idInstr <= '0;
		end else if (!stall) begin
			idInstr <= instr;
		end
	end

endmodule

`default_nettype wire

//--- src/memoryStage.sv
`default_nettype none
`include "cpu_consts.svh"

module memoryStage (
	input  logic            clk,
	input  logic            reset,
	exMemIf.memory          exMem,
	output logic            wbWrite,
	output pipePkg::regIdxT wbReg,
	output pipePkg::wordT   wbData
);
	import pipePkg::*;

	wordT dmem [`CPU_DMEM_WORDS];
	logic [`CPU_DMEM_INDEX_BITS-1:0] index;
	wordT loadData;
	wbCtrlT wbCtrlQ;
	wordT loadQ;
	wordT aluQ;
	regIdxT rdQ;

	// word index, upper address bits ignored
	assign index = exMem.aluResult[`CPU_DMEM_INDEX_BITS+1:2];
	assign loadData = dmem[index];

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU_DMEM_WORDS; i++) begin
				dmem[i] <= '0;
			end
		end else if (exMem.memCtrl.memWrite) begin
			dmem[index] <= exMem.storeData;
		end
	end

	////////////////////////////////////////
	// memory/writeback register
	////////////////////////////////////////
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wbCtrlQ <= '0;
			loadQ <= '0;
			aluQ <= '0;
			rdQ <= '0;
		end else begin
			wbCtrlQ <= exMem.wbCtrl;
			if (exMem.memCtrl.memRead) begin
				loadQ <= loadData;
			end
			aluQ <= exMem.aluResult;
			rdQ <= exMem.rd;
		end
	end

	assign wbWrite = wbCtrlQ.regWrite;
	assign wbReg   = rdQ;
	assign wbData  = wbCtrlQ.memToReg ? loadQ : aluQ;

endmodule

`default_nettype wire

//--- src/pipelineCpu.sv
`default_nettype none

module pipelineCpu (
	input  logic            clk,
	input  logic            reset,
	input  pipePkg::wordT   instr,
	output pipePkg::wordT   pc,
	output logic            wbValid,
	output pipePkg::regIdxT wbReg,
	output pipePkg::wordT   wbData
);
	import pipePkg::*;

	logic stall;
	wordT idInstr;

	idExIf idEx ();
	exMemIf exMem ();

	fetchStage u_fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.instr(instr),
		.pc(pc),
		.idInstr(idInstr)
	);

	// retirement port doubles as the writeback feedback
	decodeStage u_decode (
		.clk(clk),
		.reset(reset),
		.idInstr(idInstr),
		.wbWrite(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.stall(stall),
		.idEx(idEx.decode)
	);

	executeStage u_execute (
		.clk(clk),
		.reset(reset),
		.idEx(idEx.execute),
		.wbData(wbData),
		.wbWrite(wbValid),
		.wbReg(wbReg),
		.exMem(exMem.execute)
	);

	memoryStage u_memory (
		.clk(clk),
		.reset(reset),
		.exMem(exMem.memory),
		.wbWrite(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

`default_nettype wire
